// File: frame_av_out.f
logic/av_out_pkg.sv
logic/raster_counter.sv
logic/video_timing_stage.sv
logic/i2s_framer.sv
logic/i2s_serializer.sv
logic/frame_av_out.sv
sim/frame_av_out_assertions.sv
sim/frame_av_out_tb.sv

// File: logic/av_out_pkg.sv
// shared types for the video and audio output paths
// raster coordinates are 10 bits, so totals above 1023 do not fit
// audio slots assume 32 bit clocks per channel with 16 data bits

`default_nettype none

package av_out_pkg;

    //////////////////////////////////////////////////////////////////////
    // raster
    //////////////////////////////////////////////////////////////////////

    // one coordinate on either axis
    typedef logic [9:0] coord_t;

    // current raster position
    typedef struct packed {
        coord_t x;
        coord_t y;
    } raster_pos_t;

    // registered timing flags toward the scaler
    typedef struct packed {
        // data enable, high inside the active window
        logic de;
        // one-cycle line sync
        logic hs;
        // one-cycle frame sync
        logic vs;
    } video_flags_t;

    //////////////////////////////////////////////////////////////////////
    // pixels
    //////////////////////////////////////////////////////////////////////

    // emulator pixel, r in [11:8], g in [7:4], b in [3:0]
    typedef logic [11:0] rgb444_t;

    // scaler pixel, one byte per colour
    typedef logic [23:0] rgb888_t;

    //////////////////////////////////////////////////////////////////////
    // audio
    //////////////////////////////////////////////////////////////////////

    // signed channel sample
    typedef logic [15:0] audio_word_t;

    typedef struct packed {
        audio_word_t left;
        audio_word_t right;
    } stereo_sample_t;

    // bit position inside one 32-bit channel slot
    typedef logic [4:0] slot_index_t;

    // framer to serializer
    typedef struct packed {
        // bit clock level
        logic        sclk;
        // strobe, sclk falls after this cycle
        logic        sclk_fall;
        // word clock, 0 for left
        logic        lrck;
        slot_index_t slot;
    } i2s_tick_t;

    // data bits per slot, the rest of the slot is zero pad
    localparam int audio_bits_c = 16;

endpackage

`default_nettype wire

// File: logic/frame_av_out.sv
// video and audio output path, all on the 12.288 MHz audgen_mclk
// default raster is 400x512 with a 320x240 window, one frame per 204800 clocks
// I2S frame is 256 mclk, every output is free-running with no back-pressure

`timescale 1ns/1ps
`default_nettype none

module frame_av_out #(
    parameter int H_TOTAL   = 400,
    parameter int V_TOTAL   = 512,
    parameter int H_ACTIVE  = 320,
    parameter int V_ACTIVE  = 240,
    parameter int H_BPORCH  = 10,
    parameter int V_BPORCH  = 10,
    parameter int HS_OFFSET = 3
) (
    input  wire                             audgen_mclk,
    input  wire                             reset_n,
    // emulator side
    input  wire av_out_pkg::rgb444_t        pixel,
    input  wire av_out_pkg::stereo_sample_t sample,
    // scaler video
    output wire av_out_pkg::rgb888_t        video_rgb,
    output wire                             video_de,
    output wire                             video_hs,
    output wire                             video_vs,
    // I2S
    output wire                             audio_sclk,
    output wire                             audio_lrck,
    output wire                             audio_dac
);

    import av_out_pkg::*;

    raster_pos_t  pos;
    video_flags_t flags;
    i2s_tick_t    tick;

    //////////////////////////////////////////////////////////////////////
    // video pipeline
    //////////////////////////////////////////////////////////////////////

    // position counters
    raster_counter #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) i_raster_counter (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos)
    );

    // sync, de and pixel widening
    video_timing_stage #(
        .H_ACTIVE  (H_ACTIVE),
        .V_ACTIVE  (V_ACTIVE),
        .H_BPORCH  (H_BPORCH),
        .V_BPORCH  (V_BPORCH),
        .HS_OFFSET (HS_OFFSET)
    ) i_video_timing_stage (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pos         (pos),
        .pixel       (pixel),
        .flags       (flags),
        .rgb         (video_rgb)
    );

    // flags out to the pins
    assign video_de = flags.de;
    assign video_hs = flags.hs;
    assign video_vs = flags.vs;

    //////////////////////////////////////////////////////////////////////
    // audio pipeline
    //////////////////////////////////////////////////////////////////////

    // bit clock and slot timing
    i2s_framer i_i2s_framer (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .tick        (tick)
    );

    // sample latch and shift out
    i2s_serializer i_i2s_serializer (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .tick        (tick),
        .sample      (sample),
        .sclk        (audio_sclk),
        .lrck        (audio_lrck),
        .dac         (audio_dac)
    );

endmodule

`default_nettype wire

// File: logic/i2s_framer.sv
// bit clock is mclk divided by 4, word clock toggles every 32 bit clocks
// slot and lrck advance in step with the falling bit clock
// the tick is combinational from the counters, the serializer registers it

`timescale 1ns/1ps
`default_nettype none

module i2s_framer (
    input  wire                   audgen_mclk,
    input  wire                   reset_n,
    output av_out_pkg::i2s_tick_t tick
);

    import av_out_pkg::*;

    // mclk divider, top bit is sclk
    logic [1:0]  div_q;
    // bit position within the current channel
    slot_index_t slot_q;
    // 0 while the left channel is on the wire
    logic        lrck_q;
    // divider wraps 3 -> 0 after this cycle
    logic        fall_now;

    assign fall_now = (div_q == 2'd3);

    //////////////////////////////////////////////////////////////////////
    // divider, slot counter and word clock
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_q  <= '0;
            slot_q <= '0;
            lrck_q <= 1'b0;
        end else begin
            div_q <= div_q + 2'd1;
            if (fall_now) begin
                // one slot per bit clock
                slot_q <= slot_q + slot_index_t'(1);
                // 32 slots per channel, then swap
                if (slot_q == '1) begin
                    lrck_q <= ~lrck_q;
                end
            end
        end
    end

    // pack for the serializer
    always_comb begin
        tick.sclk      = div_q[1];
        tick.sclk_fall = fall_now;
        tick.lrck      = lrck_q;
        tick.slot      = slot_q;
    end

endmodule

`default_nettype wire

// File: logic/i2s_serializer.sv
// I2S data, msb first, 16 data bits then 16 zero bits per channel
// a new stereo pair is taken only at the start of each left half
// the first frame after reset sends silence

`timescale 1ns/1ps
`default_nettype none

module i2s_serializer (
    input  wire                             audgen_mclk,
    input  wire                             reset_n,
    input  wire av_out_pkg::i2s_tick_t      tick,
    input  wire av_out_pkg::stereo_sample_t sample,
    output logic                            sclk,
    output logic                            lrck,
    output logic                            dac
);

    import av_out_pkg::*;

    stereo_sample_t held_q;
    audio_word_t    word_now;
    logic [3:0]     bit_idx;
    logic           in_data;
    logic           data_bit;
    logic           frame_wrap;

    // last falling edge of the right half, next slot is left 0
    assign frame_wrap = tick.sclk_fall && tick.lrck && (tick.slot == '1);

    //////////////////////////////////////////////////////////////////////
    // bit select
    //////////////////////////////////////////////////////////////////////

    assign word_now = tick.lrck ? held_q.right : held_q.left;
    // slot 0 carries bit 15
    assign bit_idx  = 4'(audio_bits_c - 1) - tick.slot[3:0];
    assign in_data  = (tick.slot < slot_index_t'(audio_bits_c));
    // zero pad in the upper half of the slot
    assign data_bit = in_data ? word_now[bit_idx] : 1'b0;

    // sample latch, one pair per frame
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            held_q <= '0;
        end else if (frame_wrap) begin
            held_q <= sample;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    // clocks and data leave on the same edge
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sclk <= 1'b0;
            lrck <= 1'b0;
            dac  <= 1'b0;
        end else begin
            sclk <= tick.sclk;
            lrck <= tick.lrck;
            dac  <= data_bit;
        end
    end

endmodule

`default_nettype wire

// File: logic/raster_counter.sv
// free-running raster position, no external sync input
// H_TOTAL and V_TOTAL must both fit in a 10-bit coordinate
// position comes out of reset at x 0, y 0

`timescale 1ns/1ps
`default_nettype none

module raster_counter #(
    parameter int H_TOTAL = 400,
    parameter int V_TOTAL = 512
) (
    input  wire                     audgen_mclk,
    input  wire                     reset_n,
    output av_out_pkg::raster_pos_t pos
);

    import av_out_pkg::*;

    // last position on each axis before the wrap
    localparam coord_t X_LAST = coord_t'(H_TOTAL - 1);
    localparam coord_t Y_LAST = coord_t'(V_TOTAL - 1);

    //////////////////////////////////////////////////////////////////////
    // x and y counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            pos <= '0;
        end else begin
            // x steps every clock
            if (pos.x == X_LAST) begin
                pos.x <= '0;
                // y steps only on the x wrap
                if (pos.y == Y_LAST) begin
                    // end of frame
                    pos.y <= '0;
                end else begin
                    pos.y <= pos.y + coord_t'(1);
                end
            end else begin
                pos.x <= pos.x + coord_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/video_timing_stage.sv
// flags appear one clock after the position they decode
// rgb appears two clocks after the pixel input and is black outside de
// the window bounds must lie inside the raster totals of raster_counter

`timescale 1ns/1ps
`default_nettype none

module video_timing_stage #(
    parameter int H_ACTIVE  = 320,
    parameter int V_ACTIVE  = 240,
    parameter int H_BPORCH  = 10,
    parameter int V_BPORCH  = 10,
    parameter int HS_OFFSET = 3
) (
    input  wire                          audgen_mclk,
    input  wire                          reset_n,
    input  wire av_out_pkg::raster_pos_t pos,
    input  wire av_out_pkg::rgb444_t     pixel,
    output av_out_pkg::video_flags_t     flags,
    output av_out_pkg::rgb888_t          rgb
);

    import av_out_pkg::*;

    // active window, start inclusive and end exclusive
    localparam coord_t X_DE_START = coord_t'(H_BPORCH);
    localparam coord_t X_DE_END   = coord_t'(H_BPORCH + H_ACTIVE);
    localparam coord_t Y_DE_START = coord_t'(V_BPORCH);
    localparam coord_t Y_DE_END   = coord_t'(V_BPORCH + V_ACTIVE);
    // hs trails vs by this many clocks
    localparam coord_t X_HS       = coord_t'(HS_OFFSET);

    rgb444_t pixel_q;
    logic    in_window;
    logic    at_line_sync;
    logic    at_frame_start;

    // nibble to the high half of each byte, low nibbles zero
    function automatic rgb888_t widen(input rgb444_t p);
        return {p[11:8], 4'h0, p[7:4], 4'h0, p[3:0], 4'h0};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // position decode
    //////////////////////////////////////////////////////////////////////

    assign in_window = (pos.x >= X_DE_START) && (pos.x < X_DE_END) &&
                       (pos.y >= Y_DE_START) && (pos.y < Y_DE_END);

    assign at_line_sync   = (pos.x == X_HS);
    assign at_frame_start = (pos.x == '0) && (pos.y == '0);

    // first pixel stage
    always_ff @(posedge audgen_mclk) begin
        pixel_q <= pixel;
    end

    //////////////////////////////////////////////////////////////////////
    // registered flags and second pixel stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            flags <= '0;
            rgb   <= '0;
        end else begin
            flags.de <= in_window;
            flags.hs <= at_line_sync;
            flags.vs <= at_frame_start;
            // black in the porches, same clock as de
            rgb <= in_window ? widen(pixel_q) : '0;
        end
    end

endmodule

`default_nettype wire

// File: sim/frame_av_out_assertions.sv
// pin-level protocol checks, bound into every frame_av_out instance
// all properties pause while reset_n is low
// error_count lets the testbench see a failed property

`timescale 1ns/1ps
`default_nettype none

module frame_av_out_assertions (
    input wire                      audgen_mclk,
    input wire                      reset_n,
    input wire av_out_pkg::rgb888_t video_rgb,
    input wire                      video_de,
    input wire                      audio_sclk,
    input wire                      audio_lrck
);

    // failed properties so far
    int error_count = 0;

    // black in the porches
    rgb_black_outside_de: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        !video_de |-> (video_rgb == '0)
    ) else begin
        $error("video_rgb not black while video_de is low");
        error_count++;
    end

    // two clocks high, two low
    sclk_period_four: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        $rose(audio_sclk) |-> ##2 $fell(audio_sclk) ##2 $rose(audio_sclk)
    ) else begin
        $error("audio_sclk period is not 4 clocks");
        error_count++;
    end

    // word clock only moves with the falling bit clock
    lrck_on_sclk_fall: assert property (
        @(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $fell(audio_sclk)
    ) else begin
        $error("audio_lrck changed away from a falling audio_sclk");
        error_count++;
    end

endmodule

bind frame_av_out frame_av_out_assertions i_frame_av_out_assertions (
    .audgen_mclk (audgen_mclk),
    .reset_n     (reset_n),
    .video_rgb   (video_rgb),
    .video_de    (video_de),
    .audio_sclk  (audio_sclk),
    .audio_lrck  (audio_lrck)
);

`default_nettype wire

// File: sim/frame_av_out_tb.sv
// random pixels every clock, a new stereo pair once per I2S frame
// default raster sizes, the run covers two full video frames and a short tail
// the model tracks sync counters, a two-deep pixel history and the latched pair

`timescale 1ns/1ps
`default_nettype none

module frame_av_out_tb;

    import av_out_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int RNG_SEED     = 32'h75fe_40e0;
    localparam int H_TOTAL      = 400;
    localparam int V_TOTAL      = 512;
    localparam int H_ACTIVE     = 320;
    localparam int V_ACTIVE     = 240;
    localparam int H_BPORCH     = 10;
    localparam int V_BPORCH     = 10;
    localparam int HS_OFFSET    = 3;
    localparam int FRAME_CLKS   = H_TOTAL * V_TOTAL;
    // 2 channels x 32 bit clocks x 4 mclk
    localparam int LRCK_CLKS    = 256;

    logic           audgen_mclk;
    logic           reset_n;
    rgb444_t        pixel;
    stereo_sample_t sample;
    rgb888_t        video_rgb;
    logic           video_de, video_hs, video_vs;
    logic           audio_sclk, audio_lrck, audio_dac;

    // model state
    rgb444_t        pix_hist [2];
    stereo_sample_t captured = '0;
    logic           seen_vs = 1'b0, seen_hs = 1'b0, seen_lrck_fall = 1'b0;
    logic           de_q = 1'b0, sclk_q = 1'b0, lrck_q = 1'b0, new_sample = 1'b0;
    int             since_vs = 0, since_hs = 0, since_lrck = 0;
    int             hs_lines = 0, de_lines = 0, de_run = 0, bit_cnt = 0;
    int             frames_done = 0, bits_done = 0;

    frame_av_out #(
        .H_TOTAL   (H_TOTAL),
        .V_TOTAL   (V_TOTAL),
        .H_ACTIVE  (H_ACTIVE),
        .V_ACTIVE  (V_ACTIVE),
        .H_BPORCH  (H_BPORCH),
        .V_BPORCH  (V_BPORCH),
        .HS_OFFSET (HS_OFFSET)
    ) i_frame_av_out (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pixel       (pixel),
        .sample      (sample),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    initial begin
        audgen_mclk = 1'b0;
        forever #(CLK_PERIOD / 2) audgen_mclk = ~audgen_mclk;
    end

    task automatic end_with_failure();
        $display("Testbench failed");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        end_with_failure();
    endtask

    // timeouts and bound property failures
    task automatic report_problem(input string msg);
        $display("at %0t ns: %s", $time, msg);
        end_with_failure();
    endtask

    // nibble i goes to the top half of byte i, bottom half stays zero
    function automatic rgb888_t expand_rgb(input rgb444_t p);
        rgb888_t c;
        c = '0;
        for (int i = 0; i < 3; i++)
            c[8 * i + 4 +: 4] = p[4 * i +: 4];
        return c;
    endfunction

    task automatic check_idle();
        assert (video_rgb == '0 && !video_de && !video_hs &&
                !audio_sclk && !audio_lrck && !audio_dac)
            else report_mismatch("output active before the first video_vs");
    endtask

    ////////////////////////////////////////////////////////////////////////
    // video model
    ////////////////////////////////////////////////////////////////////////

    task automatic check_video();
        since_vs++;
        since_hs++;
        if (video_vs) begin
            // close out the frame just finished
            if (seen_vs) begin
                assert (since_vs == FRAME_CLKS)
                    else report_mismatch($sformatf("vs period %0d", since_vs));
                assert (de_lines == V_ACTIVE)
                    else report_mismatch($sformatf("%0d de lines in frame", de_lines));
                frames_done++;
            end
            seen_vs  = 1'b1;
            since_vs = 0;
            hs_lines = 0;
            de_lines = 0;
        end
        if (video_hs) begin
            // hs sits HS_OFFSET into every line
            assert (since_vs == HS_OFFSET + hs_lines * H_TOTAL)
                else report_mismatch($sformatf("hs %0d clocks after vs", since_vs));
            if (seen_hs)
                assert (since_hs == H_TOTAL)
                    else report_mismatch($sformatf("hs period %0d", since_hs));
            seen_hs  = 1'b1;
            since_hs = 0;
            hs_lines++;
        end
        if (since_vs > FRAME_CLKS)
            report_problem("video_vs did not come within one frame period");
        if (seen_hs && since_hs > H_TOTAL)
            report_problem("video_hs did not come within one line period");
        if (video_de && !de_q) begin
            // start of a de run
            assert (since_hs == H_BPORCH - HS_OFFSET)
                else report_mismatch($sformatf("de starts %0d after hs", since_hs));
            assert (hs_lines - 1 == V_BPORCH + de_lines)
                else report_mismatch($sformatf("de on line %0d", hs_lines - 1));
            de_run = 0;
        end
        if (video_de)
            de_run++;
        if (!video_de && de_q) begin
            assert (de_run == H_ACTIVE)
                else report_mismatch($sformatf("de run of %0d clocks", de_run));
            de_lines++;
        end
        // two clocks of pixel delay inside the window
        if (video_de)
            assert (video_rgb == expand_rgb(pix_hist[1]))
                else report_mismatch($sformatf("rgb %06h, want %06h",
                                               video_rgb, expand_rgb(pix_hist[1])));
        else
            assert (video_rgb == '0)
                else report_mismatch($sformatf("rgb %06h outside de", video_rgb));
        de_q = video_de;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // audio model
    ////////////////////////////////////////////////////////////////////////

    task automatic check_audio();
        audio_word_t word;
        logic        want;
        since_lrck++;
        if (audio_lrck != lrck_q) begin
            assert (bit_cnt == 32)
                else report_mismatch($sformatf("%0d bit clocks in half frame", bit_cnt));
            bit_cnt = 0;
            if (!audio_lrck) begin
                if (seen_lrck_fall)
                    assert (since_lrck == LRCK_CLKS)
                        else report_mismatch($sformatf("lrck period %0d", since_lrck));
                seen_lrck_fall = 1'b1;
                since_lrck     = 0;
                // pair latched one clock ago, input still unchanged
                captured   = sample;
                new_sample = 1'b1;
            end
        end
        if (since_lrck > LRCK_CLKS + 4)
            report_problem("audio_lrck stopped toggling");
        if (audio_sclk && !sclk_q) begin
            // msb first, then zero pad
            word = audio_lrck ? captured.right : captured.left;
            want = (bit_cnt < audio_bits_c) ? word[audio_bits_c - 1 - bit_cnt] : 1'b0;
            assert (audio_dac == want)
                else report_mismatch($sformatf("dac %0b at bit %0d, want %0b",
                                               audio_dac, bit_cnt, want));
            bit_cnt++;
            bits_done++;
        end
        sclk_q = audio_sclk;
        lrck_q = audio_lrck;
    endtask

    task automatic drive_inputs();
        pix_hist[1] = pix_hist[0];
        pixel       = rgb444_t'($urandom);
        pix_hist[0] = pixel;
        if (new_sample) begin
            sample     = stereo_sample_t'($urandom);
            new_sample = 1'b0;
        end
    endtask

    // one clock, checked and driven on the falling edge
    task automatic step();
        @(negedge audgen_mclk);
        if (!seen_vs && !video_vs) begin
            check_idle();
        end else begin
            check_video();
            check_audio();
        end
        assert (i_frame_av_out.i_frame_av_out_assertions.error_count == 0)
            else report_problem("a bound protocol property failed");
        drive_inputs();
    endtask

    initial begin
        int waited;
        void'($urandom(RNG_SEED));
        reset_n     = 1'b0;
        pixel       = rgb444_t'($urandom);
        sample      = stereo_sample_t'($urandom);
        pix_hist[0] = pixel;
        pix_hist[1] = pixel;
        repeat (RESET_CYCLES) step();
        reset_n = 1'b1;
        // vs expected one clock after release
        waited = 0;
        while (!seen_vs) begin
            if (waited == 16)
                report_problem("no video_vs within 16 clocks of reset release");
            step();
            waited++;
        end
        waited = 0;
        while (frames_done < 2) begin
            if (waited > 2 * FRAME_CLKS + 16)
                report_problem("two full video frames did not complete");
            step();
            waited++;
        end
        // a few lines into the third frame
        repeat (2 * H_TOTAL) step();
        if (bits_done > 0 && i_frame_av_out.i_frame_av_out_assertions.error_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "no audio bits checked or a bound property failed");
        end
    end

endmodule

`default_nettype wire
